//--- dv/icache_tb.sv
// instruction cache testbench
// reads fetch and fence vectors, models the burst memory with random gaps,
// keeps a shadow tag/valid copy to predict hits and misses

`timescale 1ns/1ps

module icache_tb;
	import icache_pkg::*;
	import mem_bus_pkg::*;

	localparam int max_vectors = 64;
	localparam int cycles_per_vector = 40;
	localparam int reset_cycles = 10;
	localparam logic [31:0] op_end = 32'd0;
	localparam logic [31:0] op_fetch = 32'd1;
	localparam logic [31:0] op_fence = 32'd2;
	localparam logic [31:0] rule_key = 32'h1357_9bdf; // memory content rule

	logic clock = 1'b0;
	logic reset;
	logic fetch_sel;
	logic [addr_w-1:0] fetch_addr;
	logic fetch_ready;
	logic [mem_data_w-1:0] fetch_data;
	logic fence_req;
	logic mem_req;
	logic [addr_w-1:0] mem_addr;
	logic mem_rvalid;
	logic mem_rlast;
	logic [mem_data_w-1:0] mem_rdata;

	logic [31:0] vec_mem [3*max_vectors]; // op, address, expected word
	int vec_count;
	int cycle_count = 0;
	int cycle_limit = 0; // 0 until the vectors are counted
	int burst_count = 0;
	int expected_bursts = 0;
	int last_beat_cycle = 0;
	logic [addr_w-1:0] burst_addr;
	logic [15:0] lfsr_q = 16'd80;

	// shadow copy of the cache directory
	logic [line_num-1:0] shadow_valid;
	logic [tag_w-1:0] shadow_tag [line_num];

	always #2 clock = ~clock;

	icache_top u_dut (
		.clock (clock),
		.reset (reset),
		.fetch_sel (fetch_sel),
		.fetch_addr (fetch_addr),
		.fetch_ready (fetch_ready),
		.fetch_data (fetch_data),
		.fence_req (fence_req),
		.mem_req (mem_req),
		.mem_addr (mem_addr),
		.mem_rvalid (mem_rvalid),
		.mem_rlast (mem_rlast),
		.mem_rdata (mem_rdata)
	);

	// word stored at a byte address depends on the whole word address
	function automatic logic [31:0] rule_word(input logic [addr_w-1:0] byte_addr);
		return {2'b00, byte_addr[addr_w-1:2]} ^ rule_key;
	endfunction

	// galois form for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] time %0t: %s = %h, expected %h", $time, name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	// no response and no memory traffic expected
	task automatic check_quiet(input string where);
		check_value({"fetch_ready ", where}, 32'(fetch_ready), 32'd0);
		check_value({"mem_req ", where}, 32'(mem_req), 32'd0);
	endtask

	task automatic check_burst_held;
		check_value("mem_req during burst", 32'(mem_req), 32'd1);
		check_value("mem_addr during burst", mem_addr, burst_addr);
	endtask

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	// burst memory answers each mem_req with line_beats beats and random gaps
	initial begin : memory_model
		int gap;
		mem_rvalid = 1'b0;
		mem_rlast = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clock);
			if (mem_req === 1'b1) begin
				burst_addr = mem_addr;
				burst_count = burst_count + 1;
				for (int b = 0; b < line_beats; b++) begin
					gap = 0;
					for (int k = 0; k < 2; k++) begin // two bits give a gap of 0 to 3
						gap = (gap << 1) | int'(lfsr_q[0]);
						lfsr_q = lfsr_next(lfsr_q);
					end
					repeat (gap) begin
						@(posedge clock);
						#0.5;
						mem_rvalid = 1'b0;
						mem_rlast = 1'b0;
						mem_rdata = '0;
						@(negedge clock);
						check_burst_held();
					end
					@(posedge clock);
					#0.5;
					mem_rvalid = 1'b1;
					mem_rlast = (b == line_beats - 1);
					mem_rdata = rule_word(burst_addr + addr_w'(4 * b));
					@(negedge clock);
					check_burst_held();
					if (mem_rlast) begin
						last_beat_cycle = cycle_count;
					end
				end
				@(posedge clock);
				#0.5;
				mem_rvalid = 1'b0;
				mem_rlast = 1'b0;
				mem_rdata = '0;
			end
		end
	end

	task automatic run_fetch(input logic [addr_w-1:0] addr,
			input logic [mem_data_w-1:0] expected);
		logic [index_w-1:0] idx;
		logic [tag_w-1:0] tag;
		logic predict_hit;
		logic seen;
		int bursts_before;
		int latency;
		idx = addr[offset_w +: index_w];
		tag = addr[addr_w-1 -: tag_w];
		predict_hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
		bursts_before = burst_count;
		check_value("vector word vs memory rule", expected, rule_word(addr));
		fetch_sel = 1'b1;
		fetch_addr = addr;
		@(negedge clock); // sampled at the next edge
		check_value("fetch_ready before sampling", 32'(fetch_ready), 32'd0);
		latency = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clock);
			latency++;
			if (predict_hit) begin
				check_value("mem_req on hit", 32'(mem_req), 32'd0);
			end
			seen = fetch_ready;
		end
		check_value("fetch_data vs memory rule", fetch_data, rule_word(addr));
		check_value("fetch_data vs vector", fetch_data, expected);
		check_value("mem_req at fetch_ready", 32'(mem_req), 32'd0);
		if (predict_hit) begin
			check_value("hit latency", latency, 32'd1);
			check_value("bursts on hit", burst_count, bursts_before);
		end else begin
			expected_bursts++;
			check_value("bursts on miss", burst_count, bursts_before + 1);
			check_value("mem_addr", burst_addr, {addr[addr_w-1:offset_w], {offset_w{1'b0}}});
			check_value("ready cycle after rlast", cycle_count, last_beat_cycle + 1);
		end
		shadow_valid[idx] = 1'b1;
		shadow_tag[idx] = tag;
		@(posedge clock);
		#0.5;
		fetch_sel = 1'b0;
		@(negedge clock);
		check_value("fetch_ready pulse width", 32'(fetch_ready), 32'd0);
		@(posedge clock);
		#0.5;
	endtask

	task automatic run_fence;
		fence_req = 1'b1;
		@(negedge clock);
		check_quiet("while fence requested");
		@(posedge clock);
		#0.5;
		fence_req = 1'b0;
		@(negedge clock);
		check_quiet("in fence");
		shadow_valid = '0; // every line gone
		@(posedge clock);
		#0.5;
	endtask

	initial begin : main
		logic [31:0] op;
		logic [addr_w-1:0] addr;
		logic [mem_data_w-1:0] expected;
		reset = 1'b1;
		fetch_sel = 1'b0;
		fetch_addr = '0;
		fence_req = 1'b0;
		shadow_valid = '0;

		$readmemh("dv/icache_vectors.hex", vec_mem);
		vec_count = 0;
		while (vec_count < max_vectors && (vec_mem[3*vec_count] == op_fetch
				|| vec_mem[3*vec_count] == op_fence)) begin
			vec_count++;
		end
		if (vec_count == max_vectors || vec_mem[3*vec_count] !== op_end) begin
			abort_run("vector file holds an unknown operation or lacks the end marker");
		end
		if (vec_count == 0) begin
			abort_run("vector file holds no fetch or fence operations");
		end
		cycle_limit = vec_count * cycles_per_vector;

		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge clock);
			#0.5;
			check_quiet("during reset");
		end
		reset = 1'b0;
		@(negedge clock);
		check_quiet("after reset");
		@(posedge clock);
		#0.5;

		for (int v = 0; v < vec_count; v++) begin
			op = vec_mem[3*v];
			addr = vec_mem[3*v+1];
			expected = vec_mem[3*v+2];
			if (op == op_fetch) begin
				run_fetch(addr, expected);
			end else begin
				run_fence();
			end
		end
		check_value("total bursts", burst_count, expected_bursts);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- dv/icache_vectors.hex
// columns: op address expected_word, all hex, one vector per line
// op 1 fetch, 2 fence, 0 end; word is (address >> 2) ^ 13579bdf
// first fetch after reset misses, rest of the line hits
1 00000100 13579b9f
1 00000104 13579b9e
1 00000108 13579b9d
1 0000010c 13579b9c
// more lines
1 00000110 13579b9b
1 00000114 13579b9a
1 00000120 13579b97
1 0000012c 13579b94
// index 0 conflict, lines evict each other
1 00000180 13579bbf
1 00000188 13579bbd
1 00000100 13579b9f
1 00000180 13579bbf
// index 3, high and low tags
1 80001234 33579f52
1 80001230 33579f53
1 00000130 13579b93
1 80001234 33579f52
// index 7
1 fffffff0 2ca86423
1 fffffffc 2ca86420
1 000001f0 13579ba3
1 000001fc 13579ba0
// index 0 again
1 00000000 13579bdf
1 00000008 13579bdd
// fence, cached lines miss again
2 00000000 00000000
1 00000008 13579bdd
1 00000110 13579b9b
1 00000114 13579b9a
1 000001fc 13579ba0
// two fences back to back
2 00000000 00000000
2 00000000 00000000
1 80001230 33579f53
1 80001234 33579f52
// end marker
0 00000000 00000000

//--- hw/icache_ctrl.sv
// instruction cache controller
// splits the fetch address, runs idle/check/load/fence and
// answers the fetch side on a hit or one cycle after the refill

`timescale 1ns/1ps

module icache_ctrl (
	input logic clock,
	input logic reset,
	input logic fetch_sel,
	input logic [icache_pkg::addr_w-1:0] fetch_addr,
	input logic fence_req,
	output logic fetch_ready,
	output logic [mem_bus_pkg::mem_data_w-1:0] fetch_data,
	lookup_if.ctrl lk,
	refill_if.ctrl rf,
	output logic mem_req
);
	import icache_pkg::*;

	icache_state_e state_q;
	icache_state_e state_d;
	logic resp_q; // refill answer goes out this cycle
	logic mem_req_q;
	logic accept; // new fetch taken in idle

	// address split
	assign lk.tag = fetch_addr[addr_w-1 -: tag_w];
	assign lk.index = fetch_addr[offset_w +: index_w];
	assign lk.word_sel = fetch_addr[offset_w-1 -: word_sel_w];
	assign rf.line_addr = {lk.tag, lk.index, {offset_w{1'b0}}}; // line aligned

	// while resp_q is high the requester still holds fetch_sel for the
	// request being answered, so it is not taken as a new one
	assign accept = fetch_sel && !resp_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			state_idle: begin
				if (accept) begin
					state_d = state_check;
				end else if (fence_req) begin
					state_d = state_fence;
				end
			end
			state_check: state_d = lk.hit ? state_idle : state_load;
			state_load: begin
				if (rf.done) begin
					state_d = state_idle;
				end
			end
			default: state_d = state_idle; // fence lasts one cycle
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= state_idle;
			resp_q <= 1'b0;
			mem_req_q <= 1'b0;
		end else begin
			state_q <= state_d;
			resp_q <= rf.done;
			if (rf.start) begin
				mem_req_q <= 1'b1;
			end else if (rf.done) begin
				mem_req_q <= 1'b0; // drops after the rlast beat
			end
		end
	end

	assign rf.start = (state_q == state_check) && !lk.hit;
	assign lk.invalidate_all = (state_q == state_fence);
	assign mem_req = mem_req_q;

	// the data array holds the new line by the cycle after done
	assign fetch_ready = ((state_q == state_check) && lk.hit) || resp_q;
	assign fetch_data = lk.rdata;

	// a response comes from a check hit or from a refill that ended in load
	a_ready_source: assert property (@(posedge clock) disable iff (reset)
		fetch_ready |-> (state_q == state_check) ||
			(state_q == state_idle && $past(state_q == state_load && rf.done)));

	// a fence never lands on top of a refill completion
	a_fence_vs_done: assert property (@(posedge clock) disable iff (reset)
		!(lk.invalidate_all && rf.done));

endmodule

//--- hw/icache_data_array.sv
// line data storage
// each returned beat lands in word beat_idx of the indexed line,
// the addressed word is read out combinationally

`timescale 1ns/1ps

module icache_data_array (
	input logic clock,
	lookup_if.data lk,
	refill_if.data rf
);
	import icache_pkg::*;
	import mem_bus_pkg::*;

	// line_num lines of line_beats words
	logic [mem_data_w-1:0] line_q [line_num][line_beats];

	always_ff @(posedge clock) begin
		if (rf.beat_valid) begin
			line_q[lk.index][rf.beat_idx] <= rf.beat_data; // index held by requester
		end
	end

	// word select, stale until the tag array marks it valid
	assign lk.rdata = line_q[lk.index][lk.word_sel];

endmodule

//--- hw/icache_if.sv
// cache internal interfaces
// lookup_if carries the address split and the hit and read word back
// refill_if carries the burst start and the returned beats

`timescale 1ns/1ps

interface lookup_if;
	import icache_pkg::*;
	import mem_bus_pkg::*;

	logic [index_w-1:0] index;
	logic [tag_w-1:0] tag;
	logic [word_sel_w-1:0] word_sel;
	logic hit;
	logic [mem_data_w-1:0] rdata;
	logic invalidate_all;

	modport ctrl (output index, tag, word_sel, invalidate_all, input hit, rdata);
	modport tags (input index, tag, invalidate_all, output hit);
	modport data (input index, word_sel, output rdata);
endinterface

interface refill_if;
	import icache_pkg::*;
	import mem_bus_pkg::*;

	logic start; // one cycle, miss found
	logic [addr_w-1:0] line_addr;
	logic beat_valid;
	logic [beat_cnt_w-1:0] beat_idx;
	logic [mem_data_w-1:0] beat_data;
	logic done; // last beat accepted

	modport ctrl (output start, line_addr, input done);
	modport refill (input start, line_addr, output beat_valid, beat_idx, beat_data, done);
	modport tags (input done);
	modport data (input beat_valid, beat_idx, beat_data);
endinterface

//--- hw/icache_pkg.sv
// instruction cache geometry
// direct mapped, 8 lines of 16 bytes, 32 bit fetch address
// also holds the controller state encoding

package icache_pkg;

	localparam int addr_w = 32; // fetch address
	localparam int index_w = 3; // line index bits
	localparam int offset_w = 4; // byte offset inside a line
	localparam int line_num = 1 << index_w;
	localparam int tag_w = addr_w - index_w - offset_w;

	// word in line, the two low byte bits are dropped
	localparam int word_sel_w = offset_w - 2;

	// controller states
	typedef enum logic [1:0] {
		state_idle = 2'b00,
		state_check = 2'b01, // tag compare, answers a hit
		state_load = 2'b10, // burst refill in flight
		state_fence = 2'b11 // bulk invalidate
	} icache_state_e;

endpackage

//--- hw/icache_refill.sv
// burst refill unit
// latches the line address on start, drives the memory address,
// counts returned beats and flags the last one

`timescale 1ns/1ps

module icache_refill (
	input logic clock,
	input logic reset,
	input logic mem_rvalid,
	input logic mem_rlast,
	input logic [mem_bus_pkg::mem_data_w-1:0] mem_rdata,
	refill_if.refill rf,
	output logic [icache_pkg::addr_w-1:0] mem_addr
);
	import mem_bus_pkg::*;

	logic busy_q; // burst outstanding
	logic [beat_cnt_w-1:0] cnt_q;
	logic [icache_pkg::addr_w-1:0] line_addr_q;
	logic beat;

	assign beat = busy_q && mem_rvalid;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
		end else if (rf.start) begin
			busy_q <= 1'b1;
			cnt_q <= '0;
		end else if (beat) begin
			cnt_q <= cnt_q + 1'b1; // wraps back to 0 after the last beat
			if (mem_rlast) begin
				busy_q <= 1'b0;
			end
		end
	end

	// stable for the whole burst
	always_ff @(posedge clock) begin
		if (rf.start) begin
			line_addr_q <= rf.line_addr;
		end
	end

	assign mem_addr = line_addr_q;

	assign rf.beat_valid = beat;
	assign rf.beat_idx = cnt_q;
	assign rf.beat_data = mem_rdata; // passed straight through
	assign rf.done = beat && mem_rlast;

	// memory must return exactly line_beats beats
	a_rlast_count: assert property (@(posedge clock) disable iff (reset)
		beat |-> (mem_rlast == (cnt_q == beat_cnt_w'(line_beats - 1))));

endmodule

//--- hw/icache_tag_array.sv
// tag and valid storage
// one entry per line, hit is tag compare qualified by valid
// reset and fence clear all valid bits, refill done sets one

`timescale 1ns/1ps

module icache_tag_array (
	input logic clock,
	input logic reset,
	lookup_if.tags lk,
	refill_if.tags rf
);
	import icache_pkg::*;

	logic [line_num-1:0] valid_q;
	logic [tag_w-1:0] tag_q [line_num];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else if (lk.invalidate_all) begin
			valid_q <= '0; // fence, all lines at once
		end else if (rf.done) begin
			valid_q[lk.index] <= 1'b1;
		end
	end

	// tag written together with the valid bit
	always_ff @(posedge clock) begin
		if (rf.done) begin
			tag_q[lk.index] <= lk.tag;
		end
	end

	assign lk.hit = valid_q[lk.index] && (tag_q[lk.index] == lk.tag);

endmodule

//--- hw/icache_top.sv
// direct mapped instruction cache top
// fetch side psel/pready style handshake, memory side burst read,
// controller plus tag array, data array and refill unit

`timescale 1ns/1ps

module icache_top (
	input logic clock,
	input logic reset,
	input logic fetch_sel,
	input logic [icache_pkg::addr_w-1:0] fetch_addr,
	output logic fetch_ready,
	output logic [mem_bus_pkg::mem_data_w-1:0] fetch_data,
	input logic fence_req,
	output logic mem_req,
	output logic [icache_pkg::addr_w-1:0] mem_addr,
	input logic mem_rvalid,
	input logic mem_rlast,
	input logic [mem_bus_pkg::mem_data_w-1:0] mem_rdata
);

	lookup_if lk ();
	refill_if rf ();

	icache_ctrl u_ctrl (
		.clock (clock),
		.reset (reset),
		.fetch_sel (fetch_sel),
		.fetch_addr (fetch_addr),
		.fence_req (fence_req),
		.fetch_ready (fetch_ready),
		.fetch_data (fetch_data),
		.lk (lk.ctrl),
		.rf (rf.ctrl),
		.mem_req (mem_req)
	);

	icache_tag_array u_tags (
		.clock (clock),
		.reset (reset),
		.lk (lk.tags),
		.rf (rf.tags)
	);

	icache_data_array u_data (
		.clock (clock),
		.lk (lk.data),
		.rf (rf.data)
	);

	icache_refill u_refill (
		.clock (clock),
		.reset (reset),
		.mem_rvalid (mem_rvalid),
		.mem_rlast (mem_rlast),
		.mem_rdata (mem_rdata),
		.rf (rf.refill),
		.mem_addr (mem_addr)
	);

endmodule

//--- hw/mem_bus_pkg.sv
// memory side burst read bus
// one line is line_beats beats of mem_data_w bits

package mem_bus_pkg;

	localparam int mem_data_w = 32; // beat width
	localparam int line_beats = 4; // beats per line refill
	localparam int beat_cnt_w = 2; // counts 0 .. line_beats-1

endpackage

//--- list.f
hw/icache_pkg.sv
hw/mem_bus_pkg.sv
hw/icache_if.sv
hw/icache_ctrl.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_refill.sv
hw/icache_top.sv
dv/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the instruction cache testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module icache_tb \
	--Mdir build -o icache_sim

./build/icache_sim 2>&1 | tee sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
